//--- bedrock_wb_bridge.f
hw/bwb_pkg.sv
hw/bwb_fifo.sv
hw/bwb_fwd_intake.sv
hw/bwb_wb_master.sv
hw/bwb_rev_egress.sv
hw/bwb_wb_ram.sv
hw/bwb_top.sv
tests/bwb_checker.sv
tests/bwb_tb.sv

//--- hw/bwb_fifo.sv
`timescale 1ns/1ps

module bwb_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign do_push = push_i & ~full_o;  // push into a full queue is dropped
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

//--- hw/bwb_fwd_intake.sv
`timescale 1ns/1ps

module bwb_fwd_intake #(
  parameter int DATA_W    = 64,
  parameter int ADDR_W    = 12,
  parameter int ID_W      = 4,
  parameter int CMD_DEPTH = 4,
  localparam int SEL_W    = DATA_W / 8,
  localparam int OFF_W    = $clog2(SEL_W),
  localparam int WADR_W   = ADDR_W - OFF_W
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  fwd_v_i,
  input  bwb_pkg::mem_op_e      fwd_op_i,
  input  logic [ADDR_W-1:0]     fwd_addr_i,
  input  bwb_pkg::mem_size_e    fwd_size_i,
  input  logic [ID_W-1:0]       fwd_id_i,
  input  logic [DATA_W-1:0]     fwd_data_i,
  output logic                  fwd_ready_o,
  input  logic                  cmd_pop_i,
  output logic                  cmd_v_o,
  output logic [WADR_W-1:0]     cmd_adr_o,
  output logic                  cmd_we_o,
  output logic [SEL_W-1:0]      cmd_sel_o,
  output logic [DATA_W-1:0]     cmd_dat_o,
  output logic [ID_W-1:0]       cmd_id_o,
  output bwb_pkg::mem_size_e    cmd_size_o,
  output logic [OFF_W-1:0]      cmd_off_o
);

  typedef struct packed {
    logic [WADR_W-1:0]  adr;
    logic               we;
    logic [SEL_W-1:0]   sel;
    logic [DATA_W-1:0]  dat;
    logic [ID_W-1:0]    id;
    bwb_pkg::mem_size_e size;
    logic [OFF_W-1:0]   off;
  } cmd_t;

  cmd_t             cmd_in;
  cmd_t             cmd_head;
  logic [3:0]       nbytes;
  logic [OFF_W-1:0] align_mask;
  logic [OFF_W-1:0] off;
  logic             q_empty;
  logic             q_full;

  assign nbytes     = bwb_pkg::size_bytes(fwd_size_i);
  // low address bits inside the transfer size are dropped
  assign align_mask = ~(OFF_W'(nbytes) - 1'b1);
  assign off        = fwd_addr_i[OFF_W-1:0] & align_mask;

  always_comb begin
    cmd_in      = '0;
    cmd_in.adr  = fwd_addr_i[ADDR_W-1:OFF_W];
    cmd_in.we   = (fwd_op_i == bwb_pkg::e_op_wr);
    cmd_in.dat  = fwd_data_i << {off, 3'b000};  // move data up to its lane
    cmd_in.id   = fwd_id_i;
    cmd_in.size = fwd_size_i;
    cmd_in.off  = off;
    for (int i = 0; i < SEL_W; i++) begin
      cmd_in.sel[i] = (i >= int'(off)) && (i < int'(off) + int'(nbytes));
    end
  end

  bwb_fifo #(
    .payload_t(cmd_t),
    .DEPTH    (CMD_DEPTH)
  ) u_cmd_q (
     .clk_i  (clk_i)
    ,.rst_n_i(rst_n_i)
    ,.push_i (fwd_v_i & fwd_ready_o)
    ,.data_i (cmd_in)
    ,.pop_i  (cmd_pop_i)
    ,.data_o (cmd_head)
    ,.empty_o(q_empty)
    ,.full_o (q_full)
  );

  assign fwd_ready_o = ~q_full;
  assign cmd_v_o     = ~q_empty;

  assign cmd_adr_o  = cmd_head.adr;
  assign cmd_we_o   = cmd_head.we;
  assign cmd_sel_o  = cmd_head.sel;
  assign cmd_dat_o  = cmd_head.dat;
  assign cmd_id_o   = cmd_head.id;
  assign cmd_size_o = cmd_head.size;
  assign cmd_off_o  = cmd_head.off;

endmodule

//--- hw/bwb_pkg.sv
package bwb_pkg;

  // forward command opcode
  typedef enum logic {
    e_op_rd = 1'b0,
    e_op_wr = 1'b1
  } mem_op_e;

  // transfer size in bytes, log2 encoded
  typedef enum logic [1:0] {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10,
    e_size_8 = 2'b11
  } mem_size_e;

  function automatic logic [3:0] size_bytes(input mem_size_e size);
    logic [3:0] nbytes;
    case (size)
      e_size_1: nbytes = 4'd1;
      e_size_2: nbytes = 4'd2;
      e_size_4: nbytes = 4'd4;
      default:  nbytes = 4'd8;
    endcase
    return nbytes;
  endfunction

endpackage

//--- hw/bwb_rev_egress.sv
`timescale 1ns/1ps

module bwb_rev_egress #(
  parameter int DATA_W    = 64,
  parameter int ID_W      = 4,
  parameter int RSP_DEPTH = 4,
  localparam int SEL_W    = DATA_W / 8,
  localparam int OFF_W    = $clog2(SEL_W)
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               rsp_push_i,
  input  logic [ID_W-1:0]    rsp_id_i,
  input  bwb_pkg::mem_op_e   rsp_op_i,
  input  bwb_pkg::mem_size_e rsp_size_i,
  input  logic [OFF_W-1:0]   rsp_off_i,
  input  logic [DATA_W-1:0]  rsp_dat_i,
  output logic               rsp_space_o,
  output logic               rev_v_o,
  output bwb_pkg::mem_op_e   rev_op_o,
  output bwb_pkg::mem_size_e rev_size_o,
  output logic [ID_W-1:0]    rev_id_o,
  output logic [DATA_W-1:0]  rev_data_o,
  input  logic               rev_ready_i
);

  typedef struct packed {
    logic [ID_W-1:0]    id;
    bwb_pkg::mem_op_e   op;
    bwb_pkg::mem_size_e size;
    logic [OFF_W-1:0]   off;
    logic [DATA_W-1:0]  dat;
  } rsp_t;

  rsp_t              rsp_in;
  rsp_t              rsp_head;
  logic              q_empty;
  logic              q_full;
  logic [3:0]        nbytes;
  logic [DATA_W-1:0] shifted;
  logic [DATA_W-1:0] byte_mask;

  assign rsp_in = '{id: rsp_id_i, op: rsp_op_i, size: rsp_size_i,
                    off: rsp_off_i, dat: rsp_dat_i};

  bwb_fifo #(
    .payload_t(rsp_t),
    .DEPTH    (RSP_DEPTH)
  ) u_rsp_q (
     .clk_i  (clk_i)
    ,.rst_n_i(rst_n_i)
    ,.push_i (rsp_push_i)
    ,.data_i (rsp_in)
    ,.pop_i  (rev_v_o & rev_ready_i)
    ,.data_o (rsp_head)
    ,.empty_o(q_empty)
    ,.full_o (q_full)
  );

  assign rsp_space_o = ~q_full;
  assign rev_v_o     = ~q_empty;

  // right-align the lanes of interest, zero the rest
  assign nbytes  = bwb_pkg::size_bytes(rsp_head.size);
  assign shifted = rsp_head.dat >> {rsp_head.off, 3'b000};
  always_comb begin
    for (int i = 0; i < SEL_W; i++) begin
      byte_mask[i*8 +: 8] = {8{i < int'(nbytes)}};
    end
  end

  assign rev_op_o   = rsp_head.op;
  assign rev_size_o = rsp_head.size;
  assign rev_id_o   = rsp_head.id;
  assign rev_data_o = shifted & byte_mask;

endmodule

//--- hw/bwb_top.sv
`timescale 1ns/1ps

module bwb_top #(
  parameter int DATA_W    = 64,
  parameter int ADDR_W    = 12,
  parameter int ID_W      = 4,
  parameter int CMD_DEPTH = 4,
  parameter int RSP_DEPTH = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // forward channel
  input  logic               fwd_v_i,
  input  bwb_pkg::mem_op_e   fwd_op_i,
  input  logic [ADDR_W-1:0]  fwd_addr_i,
  input  bwb_pkg::mem_size_e fwd_size_i,
  input  logic [ID_W-1:0]    fwd_id_i,
  input  logic [DATA_W-1:0]  fwd_data_i,
  output logic               fwd_ready_o,
  // reverse channel
  output logic               rev_v_o,
  output bwb_pkg::mem_op_e   rev_op_o,
  output bwb_pkg::mem_size_e rev_size_o,
  output logic [ID_W-1:0]    rev_id_o,
  output logic [DATA_W-1:0]  rev_data_o,
  input  logic               rev_ready_i
);

  localparam int SEL_W  = DATA_W / 8;
  localparam int OFF_W  = $clog2(SEL_W);
  localparam int WADR_W = ADDR_W - OFF_W;

  // intake to master
  logic               cmd_v;
  logic               cmd_pop;
  logic [WADR_W-1:0]  cmd_adr;
  logic               cmd_we;
  logic [SEL_W-1:0]   cmd_sel;
  logic [DATA_W-1:0]  cmd_dat;
  logic [ID_W-1:0]    cmd_id;
  bwb_pkg::mem_size_e cmd_size;
  logic [OFF_W-1:0]   cmd_off;

  // wishbone
  logic               wb_cyc;
  logic               wb_stb;
  logic               wb_we;
  logic [SEL_W-1:0]   wb_sel;
  logic [WADR_W-1:0]  wb_adr;
  logic [DATA_W-1:0]  wb_dat_w;
  logic [DATA_W-1:0]  wb_dat_r;
  logic               wb_ack;

  // master to egress
  logic               rsp_push;
  logic               rsp_space;
  logic [ID_W-1:0]    rsp_id;
  bwb_pkg::mem_op_e   rsp_op;
  bwb_pkg::mem_size_e rsp_size;
  logic [OFF_W-1:0]   rsp_off;
  logic [DATA_W-1:0]  rsp_dat;

  bwb_fwd_intake #(
    .DATA_W   (DATA_W),
    .ADDR_W   (ADDR_W),
    .ID_W     (ID_W),
    .CMD_DEPTH(CMD_DEPTH)
  ) u_intake (
     .clk_i      (clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.fwd_v_i    (fwd_v_i)
    ,.fwd_op_i   (fwd_op_i)
    ,.fwd_addr_i (fwd_addr_i)
    ,.fwd_size_i (fwd_size_i)
    ,.fwd_id_i   (fwd_id_i)
    ,.fwd_data_i (fwd_data_i)
    ,.fwd_ready_o(fwd_ready_o)
    ,.cmd_pop_i  (cmd_pop)
    ,.cmd_v_o    (cmd_v)
    ,.cmd_adr_o  (cmd_adr)
    ,.cmd_we_o   (cmd_we)
    ,.cmd_sel_o  (cmd_sel)
    ,.cmd_dat_o  (cmd_dat)
    ,.cmd_id_o   (cmd_id)
    ,.cmd_size_o (cmd_size)
    ,.cmd_off_o  (cmd_off)
  );

  bwb_wb_master #(
    .DATA_W(DATA_W),
    .ADDR_W(ADDR_W),
    .ID_W  (ID_W)
  ) u_master (
     .clk_i      (clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.cmd_v_i    (cmd_v)
    ,.cmd_adr_i  (cmd_adr)
    ,.cmd_we_i   (cmd_we)
    ,.cmd_sel_i  (cmd_sel)
    ,.cmd_dat_i  (cmd_dat)
    ,.cmd_id_i   (cmd_id)
    ,.cmd_size_i (cmd_size)
    ,.cmd_off_i  (cmd_off)
    ,.cmd_pop_o  (cmd_pop)
    ,.wb_cyc_o   (wb_cyc)
    ,.wb_stb_o   (wb_stb)
    ,.wb_we_o    (wb_we)
    ,.wb_sel_o   (wb_sel)
    ,.wb_adr_o   (wb_adr)
    ,.wb_dat_o   (wb_dat_w)
    ,.wb_dat_i   (wb_dat_r)
    ,.wb_ack_i   (wb_ack)
    ,.rsp_space_i(rsp_space)
    ,.rsp_push_o (rsp_push)
    ,.rsp_id_o   (rsp_id)
    ,.rsp_op_o   (rsp_op)
    ,.rsp_size_o (rsp_size)
    ,.rsp_off_o  (rsp_off)
    ,.rsp_dat_o  (rsp_dat)
  );

  bwb_rev_egress #(
    .DATA_W   (DATA_W),
    .ID_W     (ID_W),
    .RSP_DEPTH(RSP_DEPTH)
  ) u_egress (
     .clk_i      (clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.rsp_push_i (rsp_push)
    ,.rsp_id_i   (rsp_id)
    ,.rsp_op_i   (rsp_op)
    ,.rsp_size_i (rsp_size)
    ,.rsp_off_i  (rsp_off)
    ,.rsp_dat_i  (rsp_dat)
    ,.rsp_space_o(rsp_space)
    ,.rev_v_o    (rev_v_o)
    ,.rev_op_o   (rev_op_o)
    ,.rev_size_o (rev_size_o)
    ,.rev_id_o   (rev_id_o)
    ,.rev_data_o (rev_data_o)
    ,.rev_ready_i(rev_ready_i)
  );

  bwb_wb_ram #(
    .DATA_W(DATA_W),
    .ADDR_W(ADDR_W)
  ) u_ram (
     .clk_i   (clk_i)
    ,.rst_n_i (rst_n_i)
    ,.wb_cyc_i(wb_cyc)
    ,.wb_stb_i(wb_stb)
    ,.wb_we_i (wb_we)
    ,.wb_sel_i(wb_sel)
    ,.wb_adr_i(wb_adr)
    ,.wb_dat_i(wb_dat_w)
    ,.wb_dat_o(wb_dat_r)
    ,.wb_ack_o(wb_ack)
  );

endmodule

//--- hw/bwb_wb_master.sv
`timescale 1ns/1ps

module bwb_wb_master #(
  parameter int DATA_W  = 64,
  parameter int ADDR_W  = 12,
  parameter int ID_W    = 4,
  localparam int SEL_W  = DATA_W / 8,
  localparam int OFF_W  = $clog2(SEL_W),
  localparam int WADR_W = ADDR_W - OFF_W
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // command queue head
  input  logic               cmd_v_i,
  input  logic [WADR_W-1:0]  cmd_adr_i,
  input  logic               cmd_we_i,
  input  logic [SEL_W-1:0]   cmd_sel_i,
  input  logic [DATA_W-1:0]  cmd_dat_i,
  input  logic [ID_W-1:0]    cmd_id_i,
  input  bwb_pkg::mem_size_e cmd_size_i,
  input  logic [OFF_W-1:0]   cmd_off_i,
  output logic               cmd_pop_o,
  // wishbone classic
  output logic               wb_cyc_o,
  output logic               wb_stb_o,
  output logic               wb_we_o,
  output logic [SEL_W-1:0]   wb_sel_o,
  output logic [WADR_W-1:0]  wb_adr_o,
  output logic [DATA_W-1:0]  wb_dat_o,
  input  logic [DATA_W-1:0]  wb_dat_i,
  input  logic               wb_ack_i,
  // response push
  input  logic               rsp_space_i,
  output logic               rsp_push_o,
  output logic [ID_W-1:0]    rsp_id_o,
  output bwb_pkg::mem_op_e   rsp_op_o,
  output bwb_pkg::mem_size_e rsp_size_o,
  output logic [OFF_W-1:0]   rsp_off_o,
  output logic [DATA_W-1:0]  rsp_dat_o
);

  typedef enum logic {
    S_IDLE,
    S_BUSY
  } state_e;

  state_e state_q;
  logic   start;

  // a cycle only starts when its response is sure to have a slot
  assign start      = (state_q == S_IDLE) & cmd_v_i & rsp_space_i;
  assign cmd_pop_o  = start;
  assign rsp_push_o = (state_q == S_BUSY) & wb_ack_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= S_IDLE;
      wb_cyc_o <= 1'b0;
      wb_stb_o <= 1'b0;
      wb_we_o  <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: if (start) begin
          state_q  <= S_BUSY;
          wb_cyc_o <= 1'b1;
          wb_stb_o <= 1'b1;
          wb_we_o  <= cmd_we_i;
        end
        S_BUSY: if (wb_ack_i) begin
          state_q  <= S_IDLE;
          wb_cyc_o <= 1'b0;
          wb_stb_o <= 1'b0;
          wb_we_o  <= 1'b0;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // held stable for the whole cycle
  always_ff @(posedge clk_i) begin
    if (start) begin
      wb_adr_o   <= cmd_adr_i;
      wb_sel_o   <= cmd_sel_i;
      wb_dat_o   <= cmd_dat_i;
      rsp_id_o   <= cmd_id_i;
      rsp_size_o <= cmd_size_i;
      rsp_off_o  <= cmd_off_i;
    end
  end

  assign rsp_op_o  = wb_we_o ? bwb_pkg::e_op_wr : bwb_pkg::e_op_rd;
  assign rsp_dat_o = wb_we_o ? '0 : wb_dat_i;  // writes return zero

endmodule

//--- hw/bwb_wb_ram.sv
`timescale 1ns/1ps

module bwb_wb_ram #(
  parameter int DATA_W  = 64,
  parameter int ADDR_W  = 12,
  localparam int SEL_W  = DATA_W / 8,
  localparam int WADR_W = ADDR_W - $clog2(SEL_W),
  localparam int WORDS  = 2 ** WADR_W
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [SEL_W-1:0]  wb_sel_i,
  input  logic [WADR_W-1:0] wb_adr_i,
  input  logic [DATA_W-1:0] wb_dat_i,
  output logic [DATA_W-1:0] wb_dat_o,
  output logic              wb_ack_o
);

  logic [DATA_W-1:0] mem_q [WORDS];
  logic              new_req;

  // strobe seen while ack is high is the tail of the finished access
  assign new_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= new_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (new_req) begin
      if (wb_we_i) begin
        for (int i = 0; i < SEL_W; i++) begin
          if (wb_sel_i[i]) mem_q[wb_adr_i][i*8 +: 8] <= wb_dat_i[i*8 +: 8];
        end
      end else begin
        wb_dat_o <= mem_q[wb_adr_i];  // egress picks its lanes out of the full word
      end
    end
  end

endmodule

//--- tests/bwb_checker.sv
`timescale 1ns/1ps

module bwb_checker #(
  parameter int DATA_W = 64,
  parameter int ID_W   = 4,
  parameter int SEL_W  = 8,
  parameter int WADR_W = 9
) (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              wb_cyc_i,
  input logic              wb_stb_i,
  input logic              wb_we_i,
  input logic [SEL_W-1:0]  wb_sel_i,
  input logic [WADR_W-1:0] wb_adr_i,
  input logic [DATA_W-1:0] wb_dat_i,
  input logic              wb_ack_i,
  input logic              rev_v_i,
  input logic              rev_ready_i,
  input logic              rev_op_i,
  input logic [1:0]        rev_size_i,
  input logic [ID_W-1:0]   rev_id_i,
  input logic [DATA_W-1:0] rev_data_i
);

  int unsigned err_cnt = 0;  // read by the testbench at the end of each test

  a_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_stb_i |-> wb_cyc_i)
    else begin
      $error("wishbone stb high without cyc");
      err_cnt++;
    end

  // request must hold until the slave acks
  a_wb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_stb_i && !wb_ack_i |=> $stable(wb_adr_i) && $stable(wb_dat_i)
                              && $stable(wb_sel_i) && $stable(wb_we_i))
    else begin
      $error("wishbone request changed before ack");
      err_cnt++;
    end

  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |=> !wb_ack_i)
    else begin
      $error("wishbone ack high on two consecutive cycles");
      err_cnt++;
    end

  a_rev_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rev_v_i && !rev_ready_i |=> rev_v_i && $stable(rev_id_i) && $stable(rev_op_i)
                                && $stable(rev_size_i) && $stable(rev_data_i))
    else begin
      $error("reverse response changed or vanished while stalled");
      err_cnt++;
    end

  // covers the reset cycles and the first cycle after release
  a_reset_idle: assert property (@(posedge clk_i)
    !rst_n_i |=> !rev_v_i && !wb_cyc_i && !wb_stb_i)
    else begin
      $error("bridge not idle during or right after reset");
      err_cnt++;
    end

endmodule

bind bwb_top bwb_checker #(
  .DATA_W(DATA_W),
  .ID_W  (ID_W),
  .SEL_W (SEL_W),
  .WADR_W(WADR_W)
) u_checker (
   .clk_i      (clk_i)
  ,.rst_n_i    (rst_n_i)
  ,.wb_cyc_i   (wb_cyc)
  ,.wb_stb_i   (wb_stb)
  ,.wb_we_i    (wb_we)
  ,.wb_sel_i   (wb_sel)
  ,.wb_adr_i   (wb_adr)
  ,.wb_dat_i   (wb_dat_w)
  ,.wb_ack_i   (wb_ack)
  ,.rev_v_i    (rev_v_o)
  ,.rev_ready_i(rev_ready_i)
  ,.rev_op_i   (rev_op_o)
  ,.rev_size_i (rev_size_o)
  ,.rev_id_i   (rev_id_o)
  ,.rev_data_i (rev_data_o)
);

//--- tests/bwb_tb.sv
`timescale 1ns/1ps

module bwb_tb;

  localparam int DATA_W  = 64;
  localparam int ADDR_W  = 12;
  localparam int ID_W    = 4;
  localparam int TIMEOUT = 2000;

  typedef struct packed {
    logic [ID_W-1:0]    id;
    bwb_pkg::mem_op_e   op;
    bwb_pkg::mem_size_e size;
    logic [DATA_W-1:0]  data;
  } rsp_rec_t;

  logic               clk_i;
  logic               rst_n_i;
  logic               fwd_v_i;
  bwb_pkg::mem_op_e   fwd_op_i;
  logic [ADDR_W-1:0]  fwd_addr_i;
  bwb_pkg::mem_size_e fwd_size_i;
  logic [ID_W-1:0]    fwd_id_i;
  logic [DATA_W-1:0]  fwd_data_i;
  logic               fwd_ready_o;
  logic               rev_v_o;
  bwb_pkg::mem_op_e   rev_op_o;
  bwb_pkg::mem_size_e rev_size_o;
  logic [ID_W-1:0]    rev_id_o;
  logic [DATA_W-1:0]  rev_data_o;
  logic               rev_ready_i;

  logic [7:0]      ref_mem [2**ADDR_W];  // byte model of the RAM
  rsp_rec_t        exp_q [$];
  rsp_rec_t        got_q [$];
  int              ready_mode;           // 0 held low, 1 always ready, 2 stall pattern
  logic [15:0]     stall_pat;
  logic [ID_W-1:0] next_id;
  int              err_cnt;
  int              pass_cnt;
  int              fail_cnt;
  int              test_base;

  bwb_top #(
    .DATA_W   (DATA_W),
    .ADDR_W   (ADDR_W),
    .ID_W     (ID_W),
    .CMD_DEPTH(4),
    .RSP_DEPTH(4)
  ) DUT (
     .clk_i      (clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.fwd_v_i    (fwd_v_i)
    ,.fwd_op_i   (fwd_op_i)
    ,.fwd_addr_i (fwd_addr_i)
    ,.fwd_size_i (fwd_size_i)
    ,.fwd_id_i   (fwd_id_i)
    ,.fwd_data_i (fwd_data_i)
    ,.fwd_ready_o(fwd_ready_o)
    ,.rev_v_o    (rev_v_o)
    ,.rev_op_o   (rev_op_o)
    ,.rev_size_o (rev_size_o)
    ,.rev_id_o   (rev_id_o)
    ,.rev_data_o (rev_data_o)
    ,.rev_ready_i(rev_ready_i)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    #1;
    stall_pat = {stall_pat[14:0], stall_pat[15]};
    rev_ready_i = (ready_mode == 2) ? stall_pat[0] : (ready_mode == 1);
  end

  // sampled mid-cycle ahead of the edge that completes the handshake
  always @(negedge clk_i) begin
    if (rst_n_i && rev_v_o && rev_ready_i) begin
      got_q.push_back('{id: rev_id_o, op: rev_op_o, size: rev_size_o, data: rev_data_o});
    end
  end

  function automatic int total_errors();
    return err_cnt + int'(DUT.u_checker.err_cnt);
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Test failed");
    $finish;
  endtask

  function automatic void model_cmd(input bwb_pkg::mem_op_e op, input logic [ADDR_W-1:0] addr,
                                    input bwb_pkg::mem_size_e size, input logic [ID_W-1:0] id,
                                    input logic [DATA_W-1:0] data);
    rsp_rec_t          rec;
    int                nbytes;
    logic [ADDR_W-1:0] base;
    nbytes = 1 << int'(size);
    base = addr & ~ADDR_W'(nbytes - 1);  // bits inside the size are ignored
    rec.id = id;
    rec.op = op;
    rec.size = size;
    rec.data = '0;
    for (int j = 0; j < nbytes; j++) begin
      if (op == bwb_pkg::e_op_wr) ref_mem[base + j] = data[j*8 +: 8];
      else rec.data[j*8 +: 8] = ref_mem[base + j];
    end
    exp_q.push_back(rec);
  endfunction

  task automatic send_cmd(input bwb_pkg::mem_op_e op, input logic [ADDR_W-1:0] addr,
                          input bwb_pkg::mem_size_e size, input logic [DATA_W-1:0] data);
    int waited;
    waited = 0;
    fwd_v_i = 1'b1;
    fwd_op_i = op;
    fwd_addr_i = addr;
    fwd_size_i = size;
    fwd_id_i = next_id;
    fwd_data_i = data;
    @(negedge clk_i);
    while (!fwd_ready_o) begin
      waited++;
      if (waited > TIMEOUT) abort_on_timeout("fwd_ready_o stayed low with a command offered");
      @(negedge clk_i);
    end
    model_cmd(op, addr, size, next_id, data);
    next_id++;
    @(posedge clk_i);
    #1;
    fwd_v_i = 1'b0;
  endtask

  task automatic check_responses();
    rsp_rec_t exp_r;
    rsp_rec_t got_r;
    int       waited;
    waited = 0;
    while (got_q.size() < exp_q.size()) begin
      waited++;
      if (waited > TIMEOUT) abort_on_timeout("not every expected response arrived");
      @(negedge clk_i);
    end
    while (exp_q.size() > 0) begin
      exp_r = exp_q.pop_front();
      got_r = got_q.pop_front();
      assert (got_r.id == exp_r.id && got_r.op == exp_r.op && got_r.size == exp_r.size)
      else begin
        $display("FAIL %0t: response id %0h op %0d size %0d, expected id %0h op %0d size %0d",
                 $time, got_r.id, got_r.op, got_r.size, exp_r.id, exp_r.op, exp_r.size);
        err_cnt++;
      end
      assert (got_r.data === exp_r.data)
      else begin
        $display("FAIL %0t: id %0h data %h, expected %h", $time, got_r.id, got_r.data,
                 exp_r.data);
        err_cnt++;
      end
    end
    assert (got_q.size() == 0)
    else begin
      $display("FAIL %0t: %0d responses nobody asked for", $time, got_q.size());
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    if (total_errors() == test_base) begin
      pass_cnt++;
      $display("%0t %s: passed", $time, name);
    end else begin
      fail_cnt++;
      $display("%0t %s: FAILED with %0d errors", $time, name, total_errors() - test_base);
    end
    test_base = total_errors();
  endtask

  initial begin
    logic [ADDR_W-1:0] addr;
    int                nb;
    int                blocked;
    void'($urandom(82));
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    fwd_v_i = 1'b0;
    fwd_op_i = bwb_pkg::e_op_rd;
    fwd_addr_i = '0;
    fwd_size_i = bwb_pkg::e_size_1;
    fwd_id_i = '0;
    fwd_data_i = '0;
    rev_ready_i = 1'b0;
    ready_mode = 0;
    stall_pat = '1;
    next_id = '0;
    err_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    test_base = 0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    @(negedge clk_i);
    ready_mode = 1;
    assert (fwd_ready_o === 1'b1)
    else begin
      $display("FAIL %0t: fwd_ready_o is %b after reset", $time, fwd_ready_o);
      err_cnt++;
    end
    assert (rev_v_o === 1'b0)
    else begin
      $display("FAIL %0t: rev_v_o is %b after reset", $time, rev_v_o);
      err_cnt++;
    end
    end_test("reset_state");

    @(posedge clk_i);
    #1;
    for (int i = 0; i < 8; i++) begin
      send_cmd(bwb_pkg::e_op_wr, ADDR_W'(12'h080 + i * 16), bwb_pkg::e_size_8,
               {$urandom, $urandom});
    end
    for (int i = 0; i < 8; i++) begin
      send_cmd(bwb_pkg::e_op_rd, ADDR_W'(12'h080 + i * 16), bwb_pkg::e_size_8, '0);
    end
    check_responses();
    end_test("full_word_round_trip");

    @(posedge clk_i);
    #1;
    send_cmd(bwb_pkg::e_op_wr, 12'h100, bwb_pkg::e_size_8, {$urandom, $urandom});
    for (int sz = 0; sz < 3; sz++) begin
      nb = 1 << sz;
      for (int off = 0; off < 8; off += nb) begin
        send_cmd(bwb_pkg::e_op_wr, ADDR_W'(12'h100 + off), bwb_pkg::mem_size_e'(sz),
                 {$urandom, $urandom});  // upper bytes must be dropped
        send_cmd(bwb_pkg::e_op_rd, 12'h100, bwb_pkg::e_size_8, '0);  // whole word after it
      end
    end
    for (int sz = 0; sz < 4; sz++) begin
      nb = 1 << sz;
      for (int off = 0; off < 8; off += nb) begin
        send_cmd(bwb_pkg::e_op_rd, ADDR_W'(12'h100 + off), bwb_pkg::mem_size_e'(sz), '0);
      end
    end
    check_responses();
    end_test("sub_word_merging");

    @(posedge clk_i);
    #1;
    for (int i = 0; i < 12; i++) begin
      nb = 1 << (i % 4);
      addr = ADDR_W'(12'h080 + (i % 8) * 16 + (((i * 3) % 8) & ~(nb - 1)));
      send_cmd((i % 3 == 0) ? bwb_pkg::e_op_wr : bwb_pkg::e_op_rd, addr,
               bwb_pkg::mem_size_e'(i % 4), {$urandom, $urandom});
    end
    check_responses();
    end_test("ordering_in_flight");

    ready_mode = 0;
    blocked = 0;
    for (int i = 0; i < 30 && !blocked; i++) begin
      @(negedge clk_i);
      if (!fwd_ready_o) begin
        blocked = 1;
      end else begin
        @(posedge clk_i);
        #1;
        send_cmd((i % 2 == 0) ? bwb_pkg::e_op_wr : bwb_pkg::e_op_rd,
                 ADDR_W'(12'h080 + (i % 4) * 16), bwb_pkg::e_size_4, {$urandom, $urandom});
      end
    end
    if (!blocked) abort_on_timeout("fwd_ready_o never fell with rev_ready_i held low");
    repeat (6) @(negedge clk_i);  // hold the stall so the checker sees it
    ready_mode = 1;
    check_responses();
    end_test("back_pressure");

    stall_pat = 16'($urandom) | 16'h1111;
    ready_mode = 2;
    @(posedge clk_i);
    #1;
    // fill the random window first so no read sees an unwritten byte
    for (int w = 0; w < 32; w++) begin
      addr = ADDR_W'(12'h400 + w * 8);
      send_cmd(bwb_pkg::e_op_wr, addr, bwb_pkg::e_size_8,
               {addr, 4'h5, addr, 4'ha, addr, 4'h3, addr, 4'hc});
    end
    for (int i = 0; i < 200; i++) begin
      nb = $urandom_range(0, 3);
      addr = ADDR_W'(12'h400 + $urandom_range(0, 31) * 8
                     + ($urandom_range(0, 7) & ~((1 << nb) - 1)));
      send_cmd(bwb_pkg::mem_op_e'($urandom_range(0, 1)), addr, bwb_pkg::mem_size_e'(nb),
               {$urandom, $urandom});
    end
    check_responses();
    ready_mode = 1;
    end_test("random_mix");

    $display("summary: %0d tests passed, %0d tests failed, %0d errors", pass_cnt, fail_cnt,
             total_errors());
    if (fail_cnt == 0 && total_errors() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
